/* wrf_frame_relay_settings.svh */
// WRF frame relay build settings
// word widths, frame buffer and descriptor FIFO depths, flow-control margin
`ifndef WRF_FRAME_RELAY_SETTINGS_SVH
`define WRF_FRAME_RELAY_SETTINGS_SVH

// fabric word
`define WRF_DATA_W 16
`define WRF_CTRL_W 4

// frame buffer address, 512 words
`define WRF_BUF_AW 9

// descriptor FIFO address, 8 frames
`define WRF_DESC_AW 3

// sink drops tx_dreq_o below this many free words
`define WRF_DREQ_MARGIN 32

`endif

/* wrf_frame_relay_pkg.sv */
// WRF frame relay types
// fabric control codes, FSM state encodings and the RAM port owner
`include "wrf_frame_relay_settings.svh"

package wrf_frame_relay_pkg;

   // fabric control codes, stored in the buffer untouched
   typedef enum logic [`WRF_CTRL_W-1:0] {
      ctrl_none      = 4'h0,
      ctrl_dst_mac   = 4'h1,
      ctrl_src_mac   = 4'h2,
      ctrl_ethertype = 4'h3,
      ctrl_vid_prio  = 4'h4,
      ctrl_tx_oob    = 4'h5,
      ctrl_rx_oob    = 4'h6,
      ctrl_payload   = 4'h7
   } wrf_ctrl_e;

   typedef enum logic [1:0] {
      sink_idle,
      sink_store,
      sink_commit,
      sink_abort
   } sink_state_e;

   typedef enum logic [2:0] {
      src_idle,
      src_wait_dreq,
      src_sof,
      src_stream,
      src_finish
   } source_state_e;

   // owner of the single RAM port
   typedef enum logic {
      grant_sink,
      grant_source
   } grant_e;

endpackage

/* wrf_frame_ram.sv */
// Frame buffer
// single-port memory of data, control code and byte-select per word,
// read data registered
`include "wrf_frame_relay_settings.svh"

module wrf_frame_ram (
   input  logic                            clk_i,
   input  logic                            we_i,
   input  logic [`WRF_BUF_AW-1:0]          addr_i,
   input  logic [`WRF_DATA_W-1:0]          wdata_i,
   input  wrf_frame_relay_pkg::wrf_ctrl_e  wctrl_i,
   input  logic                            wbytesel_i,
   output logic [`WRF_DATA_W-1:0]          rdata_o,
   output wrf_frame_relay_pkg::wrf_ctrl_e  rctrl_o,
   output logic                            rbytesel_o
);
   import wrf_frame_relay_pkg::*;

   localparam int DEPTH = 1 << `WRF_BUF_AW;

   logic [`WRF_DATA_W-1:0] data_mem [DEPTH];
   wrf_ctrl_e              ctrl_mem [DEPTH];
   logic                   bytesel_mem [DEPTH];

   // read returns the old word on a write to the same address
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         data_mem[addr_i]    <= wdata_i;
         ctrl_mem[addr_i]    <= wctrl_i;
         bytesel_mem[addr_i] <= wbytesel_i;
      end
      rdata_o    <= data_mem[addr_i];
      rctrl_o    <= ctrl_mem[addr_i];
      rbytesel_o <= bytesel_mem[addr_i];
   end

endmodule

/* wrf_buffer_arbiter.sv */
// Frame buffer arbiter
// shares the RAM port between the sink (writes) and the source (reads),
// sink first; read data valid one cycle after the read grant
`include "wrf_frame_relay_settings.svh"

module wrf_buffer_arbiter (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  logic                            wr_req_i,
   input  logic [`WRF_BUF_AW-1:0]          wr_addr_i,
   input  logic [`WRF_DATA_W-1:0]          wr_data_i,
   input  wrf_frame_relay_pkg::wrf_ctrl_e  wr_ctrl_i,
   input  logic                            wr_bytesel_i,
   input  logic                            rd_req_i,
   input  logic [`WRF_BUF_AW-1:0]          rd_addr_i,
   output logic                            rd_grant_o,
   output logic                            rd_valid_o,
   output logic                            ram_we_o,
   output logic [`WRF_BUF_AW-1:0]          ram_addr_o,
   output logic [`WRF_DATA_W-1:0]          ram_wdata_o,
   output wrf_frame_relay_pkg::wrf_ctrl_e  ram_wctrl_o,
   output logic                            ram_wbytesel_o
);
   import wrf_frame_relay_pkg::*;

   grant_e owner;

   // at most one write per cycle, so reads are never held off for long
   assign owner = wr_req_i ? grant_sink : grant_source;

   assign rd_grant_o     = rd_req_i && (owner == grant_source);
   assign ram_we_o       = wr_req_i;
   assign ram_addr_o     = (owner == grant_sink) ? wr_addr_i : rd_addr_i;
   assign ram_wdata_o    = wr_data_i;
   assign ram_wctrl_o    = wr_ctrl_i;
   assign ram_wbytesel_o = wr_bytesel_i;

   // RAM read latency
   always_ff @(posedge clk_i) begin
      if (!rst_n_i)
         rd_valid_o <= 1'b0;
      else
         rd_valid_o <= rd_grant_o;
   end

   // write and read grant never share a cycle
   a_no_shared_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(ram_we_o && rd_grant_o));

endmodule

/* wrf_desc_fifo.sv */
// Frame descriptor FIFO
// circular queue of committed frames, start address and word count,
// head visible while not empty
`include "wrf_frame_relay_settings.svh"

module wrf_desc_fifo (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   push_i,
   input  logic [`WRF_BUF_AW-1:0] start_i,
   input  logic [`WRF_BUF_AW-1:0] len_i,
   input  logic                   pop_i,
   output logic [`WRF_BUF_AW-1:0] start_o,
   output logic [`WRF_BUF_AW-1:0] len_o,
   output logic                   full_o,
   output logic                   empty_o
);

   localparam int DEPTH = 1 << `WRF_DESC_AW;

   logic [`WRF_BUF_AW-1:0] start_mem [DEPTH];
   logic [`WRF_BUF_AW-1:0] len_mem [DEPTH];
   // extra bit tells full from empty
   logic [`WRF_DESC_AW:0]  wr_ptr;
   logic [`WRF_DESC_AW:0]  rd_ptr;

   assign empty_o = (wr_ptr == rd_ptr);
   assign full_o  = (wr_ptr[`WRF_DESC_AW] != rd_ptr[`WRF_DESC_AW]) &&
                    (wr_ptr[`WRF_DESC_AW-1:0] == rd_ptr[`WRF_DESC_AW-1:0]);
   assign start_o = start_mem[rd_ptr[`WRF_DESC_AW-1:0]];
   assign len_o   = len_mem[rd_ptr[`WRF_DESC_AW-1:0]];

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         start_mem[wr_ptr[`WRF_DESC_AW-1:0]] <= start_i;
         len_mem[wr_ptr[`WRF_DESC_AW-1:0]]   <= len_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push_i)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_i)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   a_push_not_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      push_i |-> !full_o);
   a_pop_not_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pop_i |-> !empty_o);

endmodule

/* wrf_frame_sink.sv */
// WRF sink receiver
// stores incoming frames in the shared buffer, tracks free space against
// the source release address, commits good frames to the descriptor FIFO,
// rewinds on receive error or overflow
`include "wrf_frame_relay_settings.svh"

module wrf_frame_sink (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  logic [`WRF_DATA_W-1:0]          tx_data_i,
   input  wrf_frame_relay_pkg::wrf_ctrl_e  tx_ctrl_i,
   input  logic                            tx_bytesel_i,
   input  logic                            tx_sof_p1_i,
   input  logic                            tx_eof_p1_i,
   input  logic                            tx_valid_i,
   input  logic                            tx_rerror_p1_i,
   output logic                            tx_dreq_o,
   output logic                            tx_rabort_p1_o,
   output logic                            wr_req_o,
   output logic [`WRF_BUF_AW-1:0]          wr_addr_o,
   output logic [`WRF_DATA_W-1:0]          wr_data_o,
   output wrf_frame_relay_pkg::wrf_ctrl_e  wr_ctrl_o,
   output logic                            wr_bytesel_o,
   output logic                            desc_push_o,
   output logic [`WRF_BUF_AW-1:0]          desc_start_o,
   output logic [`WRF_BUF_AW-1:0]          desc_len_o,
   input  logic                            desc_full_i,
   input  logic [`WRF_BUF_AW-1:0]          release_addr_i
);
   import wrf_frame_relay_pkg::*;

   sink_state_e            state;
   logic [`WRF_BUF_AW-1:0] wr_ptr;
   logic [`WRF_BUF_AW-1:0] frame_start;
   logic [`WRF_BUF_AW-1:0] frame_len;
   logic [`WRF_BUF_AW-1:0] free_words;

   // one slot stays empty so a full buffer is not mistaken for an empty one
   assign free_words = release_addr_i - wr_ptr - 1'b1;

   assign tx_dreq_o    = (free_words >= `WRF_BUF_AW'(`WRF_DREQ_MARGIN)) && !desc_full_i;
   assign desc_push_o  = (state == sink_commit) && !desc_full_i;
   assign desc_start_o = frame_start;
   assign desc_len_o   = frame_len;

   //////////////////////////////
   // frame FSM
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state          <= sink_idle;
         wr_ptr         <= '0;
         frame_start    <= '0;
         frame_len      <= '0;
         wr_req_o       <= 1'b0;
         tx_rabort_p1_o <= 1'b0;
      end else begin
         wr_req_o       <= 1'b0;
         tx_rabort_p1_o <= 1'b0;
         case (state)
            // after an overflow, input waits here for the next SOF
            sink_idle, sink_abort: begin
               if (tx_sof_p1_i) begin
                  frame_len <= '0;
                  state     <= sink_store;
               end
            end
            sink_store: begin
               if (tx_rerror_p1_i) begin
                  wr_ptr <= frame_start;
                  state  <= sink_idle;
               end else if (tx_valid_i) begin
                  if (free_words == '0) begin
                     wr_ptr         <= frame_start;
                     tx_rabort_p1_o <= 1'b1;
                     state          <= sink_abort;
                  end else begin
                     wr_req_o  <= 1'b1;
                     wr_ptr    <= wr_ptr + 1'b1;
                     frame_len <= frame_len + 1'b1;
                     if (tx_eof_p1_i)
                        state <= sink_commit;
                  end
               end
            end
            sink_commit: begin
               // no descriptor slot, the frame is lost
               if (desc_full_i)
                  wr_ptr <= frame_start;
               else
                  frame_start <= wr_ptr;
               state <= sink_idle;
            end
            default: state <= sink_idle;
         endcase
      end
   end

   // word goes to the RAM one cycle after it is sampled
   always_ff @(posedge clk_i) begin
      if (tx_valid_i) begin
         wr_addr_o    <= wr_ptr;
         wr_data_o    <= tx_data_i;
         wr_ctrl_o    <= tx_ctrl_i;
         wr_bytesel_o <= tx_bytesel_i;
      end
   end

   a_idle_no_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (state == sink_idle) |-> !wr_req_o);
   a_rabort_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tx_rabort_p1_o |=> !tx_rabort_p1_o);

endmodule

/* wrf_frame_source.sv */
// WRF source transmitter
// replays committed frames from the shared buffer with SOF/EOF pulses,
// paced by rx_dreq_i; a one-word skid register holds a word read before
// dreq fell, and the release address moves when a frame ends or is aborted
`include "wrf_frame_relay_settings.svh"

module wrf_frame_source (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   output logic [`WRF_DATA_W-1:0]          rx_data_o,
   output wrf_frame_relay_pkg::wrf_ctrl_e  rx_ctrl_o,
   output logic                            rx_bytesel_o,
   output logic                            rx_sof_p1_o,
   output logic                            rx_eof_p1_o,
   output logic                            rx_valid_o,
   output logic                            rx_idle_o,
   input  logic                            rx_dreq_i,
   input  logic                            rx_rabort_p1_i,
   output logic                            rd_req_o,
   output logic [`WRF_BUF_AW-1:0]          rd_addr_o,
   input  logic                            rd_grant_i,
   input  logic                            rd_valid_i,
   input  logic [`WRF_DATA_W-1:0]          rd_data_i,
   input  wrf_frame_relay_pkg::wrf_ctrl_e  rd_ctrl_i,
   input  logic                            rd_bytesel_i,
   output logic                            desc_pop_o,
   input  logic [`WRF_BUF_AW-1:0]          desc_start_i,
   input  logic [`WRF_BUF_AW-1:0]          desc_len_i,
   input  logic                            desc_empty_i,
   output logic [`WRF_BUF_AW-1:0]          release_addr_o
);
   import wrf_frame_relay_pkg::*;

   source_state_e          state;
   logic [`WRF_BUF_AW-1:0] frame_start;
   logic [`WRF_BUF_AW-1:0] frame_len;
   logic [`WRF_BUF_AW-1:0] rd_cnt;
   logic [`WRF_BUF_AW-1:0] out_cnt;
   logic                   skid_valid;
   logic [`WRF_DATA_W-1:0] skid_data;
   wrf_ctrl_e              skid_ctrl;
   logic                   skid_bytesel;
   logic                   streaming;
   logic                   take;
   logic                   last;

   assign desc_pop_o  = (state == src_idle) && !desc_empty_i;
   assign rx_sof_p1_o = (state == src_sof);
   assign rx_idle_o   = (state == src_idle) && desc_empty_i;

   // reads and output only move while the far end asks for data
   assign streaming = (state == src_stream) && rx_dreq_i && !rx_rabort_p1_i;
   assign rd_req_o  = streaming && (rd_cnt != frame_len);
   assign rd_addr_o = frame_start + rd_cnt;
   // skid word goes out before the word arriving from the RAM
   assign take      = streaming && (skid_valid || rd_valid_i);
   assign last      = (out_cnt == frame_len - 1'b1);

   //////////////////////////////
   // frame FSM
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state          <= src_idle;
         frame_start    <= '0;
         frame_len      <= '0;
         rd_cnt         <= '0;
         out_cnt        <= '0;
         skid_valid     <= 1'b0;
         release_addr_o <= '0;
         rx_valid_o     <= 1'b0;
         rx_eof_p1_o    <= 1'b0;
         rx_bytesel_o   <= 1'b0;
      end else begin
         rx_valid_o   <= 1'b0;
         rx_eof_p1_o  <= 1'b0;
         rx_bytesel_o <= 1'b0;
         case (state)
            src_idle: begin
               if (!desc_empty_i) begin
                  frame_start <= desc_start_i;
                  frame_len   <= desc_len_i;
                  rd_cnt      <= '0;
                  out_cnt     <= '0;
                  state       <= src_wait_dreq;
               end
            end
            src_wait_dreq: begin
               if (rx_dreq_i)
                  state <= src_sof;
            end
            src_sof: state <= src_stream;
            src_stream: begin
               if (rx_rabort_p1_i) begin
                  // words still in flight are dropped
                  skid_valid <= 1'b0;
                  state      <= src_finish;
               end else begin
                  if (rd_req_o && rd_grant_i)
                     rd_cnt <= rd_cnt + 1'b1;
                  if (take) begin
                     rx_valid_o   <= 1'b1;
                     rx_eof_p1_o  <= last;
                     rx_bytesel_o <= (skid_valid ? skid_bytesel : rd_bytesel_i) && last;
                     out_cnt      <= out_cnt + 1'b1;
                     skid_valid   <= skid_valid && rd_valid_i;
                     if (last)
                        state <= src_finish;
                  end else if (rd_valid_i) begin
                     skid_valid <= 1'b1;
                  end
               end
            end
            src_finish: begin
               release_addr_o <= frame_start + frame_len;
               state          <= src_idle;
            end
            default: state <= src_idle;
         endcase
      end
   end

   //////////////////////////////
   // output and skid words
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (take) begin
         rx_data_o <= skid_valid ? skid_data : rd_data_i;
         rx_ctrl_o <= skid_valid ? skid_ctrl : rd_ctrl_i;
      end
      if (rd_valid_i && !(take && !skid_valid)) begin
         skid_data    <= rd_data_i;
         skid_ctrl    <= rd_ctrl_i;
         skid_bytesel <= rd_bytesel_i;
      end
   end

   // previous frame has fully drained before the next SOF
   a_sof_not_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(rx_valid_o && rx_sof_p1_o));

endmodule

/* wrf_frame_relay.sv */
// WRF store-and-forward frame relay
// frames received on the tx sink are buffered and replayed in order on
// the rx source; sink and source share one RAM port through the arbiter
`include "wrf_frame_relay_settings.svh"

module wrf_frame_relay (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  logic [`WRF_DATA_W-1:0]          tx_data_i,
   input  wrf_frame_relay_pkg::wrf_ctrl_e  tx_ctrl_i,
   input  logic                            tx_bytesel_i,
   input  logic                            tx_sof_p1_i,
   input  logic                            tx_eof_p1_i,
   input  logic                            tx_valid_i,
   input  logic                            tx_rerror_p1_i,
   output logic                            tx_dreq_o,
   output logic                            tx_rabort_p1_o,
   output logic [`WRF_DATA_W-1:0]          rx_data_o,
   output wrf_frame_relay_pkg::wrf_ctrl_e  rx_ctrl_o,
   output logic                            rx_bytesel_o,
   output logic                            rx_sof_p1_o,
   output logic                            rx_eof_p1_o,
   output logic                            rx_valid_o,
   output logic                            rx_idle_o,
   input  logic                            rx_dreq_i,
   input  logic                            rx_rabort_p1_i
);
   import wrf_frame_relay_pkg::*;

   // sink write request
   logic                   wr_req;
   logic [`WRF_BUF_AW-1:0] wr_addr;
   logic [`WRF_DATA_W-1:0] wr_data;
   wrf_ctrl_e              wr_ctrl;
   logic                   wr_bytesel;
   // source read request
   logic                   rd_req;
   logic [`WRF_BUF_AW-1:0] rd_addr;
   logic                   rd_grant;
   logic                   rd_valid;
   // RAM port
   logic                   ram_we;
   logic [`WRF_BUF_AW-1:0] ram_addr;
   logic [`WRF_DATA_W-1:0] ram_wdata;
   wrf_ctrl_e              ram_wctrl;
   logic                   ram_wbytesel;
   logic [`WRF_DATA_W-1:0] ram_rdata;
   wrf_ctrl_e              ram_rctrl;
   logic                   ram_rbytesel;
   // descriptors and buffer release
   logic                   desc_push;
   logic                   desc_pop;
   logic [`WRF_BUF_AW-1:0] desc_start_in;
   logic [`WRF_BUF_AW-1:0] desc_len_in;
   logic [`WRF_BUF_AW-1:0] desc_start_out;
   logic [`WRF_BUF_AW-1:0] desc_len_out;
   logic                   desc_full;
   logic                   desc_empty;
   logic [`WRF_BUF_AW-1:0] release_addr;

   wrf_frame_sink u_sink (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .tx_data_i      (tx_data_i),
      .tx_ctrl_i      (tx_ctrl_i),
      .tx_bytesel_i   (tx_bytesel_i),
      .tx_sof_p1_i    (tx_sof_p1_i),
      .tx_eof_p1_i    (tx_eof_p1_i),
      .tx_valid_i     (tx_valid_i),
      .tx_rerror_p1_i (tx_rerror_p1_i),
      .tx_dreq_o      (tx_dreq_o),
      .tx_rabort_p1_o (tx_rabort_p1_o),
      .wr_req_o       (wr_req),
      .wr_addr_o      (wr_addr),
      .wr_data_o      (wr_data),
      .wr_ctrl_o      (wr_ctrl),
      .wr_bytesel_o   (wr_bytesel),
      .desc_push_o    (desc_push),
      .desc_start_o   (desc_start_in),
      .desc_len_o     (desc_len_in),
      .desc_full_i    (desc_full),
      .release_addr_i (release_addr)
   );

   wrf_frame_source u_source (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .rx_data_o      (rx_data_o),
      .rx_ctrl_o      (rx_ctrl_o),
      .rx_bytesel_o   (rx_bytesel_o),
      .rx_sof_p1_o    (rx_sof_p1_o),
      .rx_eof_p1_o    (rx_eof_p1_o),
      .rx_valid_o     (rx_valid_o),
      .rx_idle_o      (rx_idle_o),
      .rx_dreq_i      (rx_dreq_i),
      .rx_rabort_p1_i (rx_rabort_p1_i),
      .rd_req_o       (rd_req),
      .rd_addr_o      (rd_addr),
      .rd_grant_i     (rd_grant),
      .rd_valid_i     (rd_valid),
      .rd_data_i      (ram_rdata),
      .rd_ctrl_i      (ram_rctrl),
      .rd_bytesel_i   (ram_rbytesel),
      .desc_pop_o     (desc_pop),
      .desc_start_i   (desc_start_out),
      .desc_len_i     (desc_len_out),
      .desc_empty_i   (desc_empty),
      .release_addr_o (release_addr)
   );

   wrf_buffer_arbiter u_arbiter (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .wr_req_i       (wr_req),
      .wr_addr_i      (wr_addr),
      .wr_data_i      (wr_data),
      .wr_ctrl_i      (wr_ctrl),
      .wr_bytesel_i   (wr_bytesel),
      .rd_req_i       (rd_req),
      .rd_addr_i      (rd_addr),
      .rd_grant_o     (rd_grant),
      .rd_valid_o     (rd_valid),
      .ram_we_o       (ram_we),
      .ram_addr_o     (ram_addr),
      .ram_wdata_o    (ram_wdata),
      .ram_wctrl_o    (ram_wctrl),
      .ram_wbytesel_o (ram_wbytesel)
   );

   wrf_frame_ram u_ram (
      .clk_i      (clk_i),
      .we_i       (ram_we),
      .addr_i     (ram_addr),
      .wdata_i    (ram_wdata),
      .wctrl_i    (ram_wctrl),
      .wbytesel_i (ram_wbytesel),
      .rdata_o    (ram_rdata),
      .rctrl_o    (ram_rctrl),
      .rbytesel_o (ram_rbytesel)
   );

   wrf_desc_fifo u_desc_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (desc_push),
      .start_i (desc_start_in),
      .len_i   (desc_len_in),
      .pop_i   (desc_pop),
      .start_o (desc_start_out),
      .len_o   (desc_len_out),
      .full_o  (desc_full),
      .empty_o (desc_empty)
   );

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset
// 40 unit clock period, reset held low for 16 cycles and released
// on a falling edge
module tb_clock_gen (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #20 clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (16) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

/* wrf_frame_relay_tb.sv */
// WRF frame relay testbench
// reads frame commands from the test file, drives the tx sink, and checks
// every frame leaving the rx source against a scoreboard of expected frames;
// rx_dreq_i is randomized, held low for overflow lines
`include "wrf_frame_relay_settings.svh"

module wrf_frame_relay_tb;
   import wrf_frame_relay_pkg::*;

   localparam int WAIT_LIMIT  = 5000;
   localparam int DRAIN_LIMIT = 40000;

   logic                   clk;
   logic                   rst_n;
   logic [`WRF_DATA_W-1:0] tx_data;
   wrf_ctrl_e              tx_ctrl;
   logic                   tx_bytesel;
   logic                   tx_sof;
   logic                   tx_eof;
   logic                   tx_valid;
   logic                   tx_rerror;
   logic                   tx_dreq;
   logic                   tx_rabort;
   logic [`WRF_DATA_W-1:0] rx_data;
   wrf_ctrl_e              rx_ctrl;
   logic                   rx_bytesel;
   logic                   rx_sof;
   logic                   rx_eof;
   logic                   rx_valid;
   logic                   rx_idle;
   logic                   rx_dreq;
   logic                   rx_rabort;

   // scoreboard of frames expected on the source
   int          q_len[$];
   int          q_odd[$];
   int          q_abort[$];
   logic [15:0] q_start[$];

   int          mismatch_count = 0;
   int          fail_count = 0;
   int          frames_done = 0;
   int          rabort_seen = 0;
   int          rabort_expected = 0;
   int          seed = 32'he9eb540e;
   logic        hold = 1'b0;
   logic        timed_out = 1'b0;

   // monitor state
   logic        active = 1'b0;
   logic        in_tail = 1'b0;
   int          tail_words;
   int          idx;
   int          cur_len;
   int          cur_odd;
   int          cur_abort;
   logic [15:0] cur_start;

   tb_clock_gen u_clock (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   wrf_frame_relay uut (
      .clk_i          (clk),
      .rst_n_i        (rst_n),
      .tx_data_i      (tx_data),
      .tx_ctrl_i      (tx_ctrl),
      .tx_bytesel_i   (tx_bytesel),
      .tx_sof_p1_i    (tx_sof),
      .tx_eof_p1_i    (tx_eof),
      .tx_valid_i     (tx_valid),
      .tx_rerror_p1_i (tx_rerror),
      .tx_dreq_o      (tx_dreq),
      .tx_rabort_p1_o (tx_rabort),
      .rx_data_o      (rx_data),
      .rx_ctrl_o      (rx_ctrl),
      .rx_bytesel_o   (rx_bytesel),
      .rx_sof_p1_o    (rx_sof),
      .rx_eof_p1_o    (rx_eof),
      .rx_valid_o     (rx_valid),
      .rx_idle_o      (rx_idle),
      .rx_dreq_i      (rx_dreq),
      .rx_rabort_p1_i (rx_rabort)
   );

   // header words first: 3 dst_mac, 3 src_mac, 1 ethertype
   function automatic wrf_ctrl_e expected_ctrl(input int i);
      if (i < 3)
         return ctrl_dst_mac;
      if (i < 6)
         return ctrl_src_mac;
      if (i == 6)
         return ctrl_ethertype;
      return ctrl_payload;
   endfunction

   task automatic report_failure(input string what);
      fail_count++;
      $display("%s", what);
   endtask

   task automatic compare_field(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
      assert (got === exp) else begin
         mismatch_count++;
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic wait_tx_dreq();
      int n;
      n = 0;
      while (!tx_dreq && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      assert (tx_dreq) else begin
         timed_out = 1'b1;
         report_failure("timeout waiting for tx_dreq_o to rise");
      end
   endtask

   // errpos counts from 1; that word is replaced by a receive error
   task automatic send_frame(input int len, input int odd, input logic [15:0] start,
                             input int errpos, input logic overflow);
      int   i;
      logic seen_abort;
      logic seen_low;
      seen_abort = 1'b0;
      seen_low   = 1'b0;
      tx_sof = 1'b1;
      @(negedge clk);
      tx_sof = 1'b0;
      for (i = 0; i < len; i++) begin
         if (errpos != 0 && i == errpos - 1) begin
            tx_rerror = 1'b1;
            @(negedge clk);
            tx_rerror = 1'b0;
            break;
         end
         tx_valid   = 1'b1;
         tx_data    = start + i;
         tx_ctrl    = expected_ctrl(i);
         tx_bytesel = (odd != 0) && (i == len - 1);
         tx_eof     = (i == len - 1);
         @(negedge clk);
         if (tx_rabort)
            seen_abort = 1'b1;
         else if (!seen_abort && !tx_dreq)
            seen_low = 1'b1;
      end
      tx_valid   = 1'b0;
      tx_eof     = 1'b0;
      tx_bytesel = 1'b0;
      @(negedge clk);
      if (tx_rabort)
         seen_abort = 1'b1;
      if (overflow) begin
         assert (seen_abort) else report_failure("no tx_rabort_p1_o on a buffer overflow");
         assert (seen_low) else report_failure("tx_dreq_o stayed high up to the overflow");
      end
      // let the sink commit before the next SOF
      @(negedge clk);
   endtask

   //////////////////////////////
   // source monitor, rx_dreq_i
   //////////////////////////////

   always @(negedge clk) begin
      rx_rabort = 1'b0;
      if (rst_n) begin
         if (tx_rabort)
            rabort_seen++;
         if (rx_sof || rx_valid)
            assert (!rx_idle) else report_failure("rx_idle_o high while a frame is sent");
         if (rx_sof) begin
            assert (!active) else report_failure("SOF arrived before the previous frame ended");
            assert (!rx_valid) else report_failure("SOF came together with a data word");
            assert (q_len.size() != 0) else report_failure("SOF with no frame expected");
            in_tail = 1'b0;
            if (q_len.size() != 0) begin
               cur_len   = q_len.pop_front();
               cur_odd   = q_odd.pop_front();
               cur_abort = q_abort.pop_front();
               cur_start = q_start.pop_front();
               idx       = 0;
               active    = 1'b1;
            end
         end
         if (rx_valid) begin
            // rx_dreq still holds the value sampled on the last rising edge
            assert (rx_dreq) else report_failure("word emitted after rx_dreq_i was low");
            assert (active || in_tail) else report_failure("word emitted outside a frame");
            if (active) begin
               compare_field("rx_data_o", rx_data, cur_start + idx);
               compare_field("rx_ctrl_o", rx_ctrl, expected_ctrl(idx));
               compare_field("rx_bytesel_o", rx_bytesel, (cur_odd != 0) && (idx == cur_len - 1));
               compare_field("rx_eof_p1_o", rx_eof, idx == cur_len - 1);
               idx++;
               if (idx == cur_len) begin
                  active = 1'b0;
                  frames_done++;
               end else if (idx == cur_abort) begin
                  rx_rabort  = 1'b1;
                  active     = 1'b0;
                  in_tail    = 1'b1;
                  tail_words = 0;
                  frames_done++;
               end
            end else if (in_tail) begin
               tail_words++;
               assert (tail_words <= 2 && !rx_eof)
                  else report_failure("aborted frame went on past the abort");
            end
         end
      end
      rx_dreq = hold ? 1'b0 : (($random(seed) & 3) != 0);
   end

   //////////////////////////////
   // command sequence
   //////////////////////////////

   initial begin
      int          fd;
      int          code;
      int          c;
      int          len;
      int          odd;
      int          errpos;
      int          n;
      logic [15:0] start;
      logic [63:0] cmd;
      logic [63:0] outcome;
      tx_data    = '0;
      tx_ctrl    = ctrl_none;
      tx_bytesel = 1'b0;
      tx_sof     = 1'b0;
      tx_eof     = 1'b0;
      tx_valid   = 1'b0;
      tx_rerror  = 1'b0;
      rx_dreq    = 1'b0;
      rx_rabort  = 1'b0;
      fd = $fopen("wrf_frame_relay_tests.txt", "r");
      assert (fd != 0) else report_failure("cannot open wrf_frame_relay_tests.txt");
      n = 0;
      while (!rst_n && n < WAIT_LIMIT) begin
         @(posedge clk);
         n++;
      end
      assert (rst_n) else begin
         timed_out = 1'b1;
         report_failure("timeout waiting for the reset to be released");
      end
      @(negedge clk);
      assert (rx_idle && tx_dreq && !rx_valid && !rx_sof && !rx_eof && !tx_rabort)
         else report_failure("outputs not at their reset values after the reset");
      while (fd != 0 && !timed_out) begin
         code = $fscanf(fd, "%s", cmd);
         if (code != 1)
            break;
         if (cmd == "#") begin
            c = $fgetc(fd);
            while (c != "\n" && c != -1)
               c = $fgetc(fd);
            continue;
         end
         code = $fscanf(fd, "%d %d %h %d %s", len, odd, start, errpos, outcome);
         assert (code == 5) else report_failure("malformed line in the test file");
         wait_tx_dreq();
         if (timed_out)
            break;
         if (outcome == "pass") begin
            q_len.push_back(len);
            q_odd.push_back(odd);
            q_start.push_back(start);
            q_abort.push_back(cmd == "abort" ? errpos : 0);
         end else if (outcome == "overrun") begin
            rabort_expected++;
         end
         if (cmd == "send")
            send_frame(len, odd, start, errpos, 1'b0);
         else if (cmd == "abort")
            send_frame(len, odd, start, 0, 1'b0);
         else if (cmd == "hold") begin
            hold <= 1'b1;
            send_frame(len, odd, start, errpos, 1'b1);
            hold <= 1'b0;
         end else
            report_failure("unknown command in the test file");
      end
      if (fd != 0)
         $fclose(fd);
      n = 0;
      while (!timed_out && (q_len.size() != 0 || active || !rx_idle) && n < DRAIN_LIMIT) begin
         @(negedge clk);
         n++;
      end
      assert (timed_out || n < DRAIN_LIMIT)
         else report_failure("timeout waiting for the source to send all frames");
      repeat (4) @(negedge clk);
      assert (rabort_seen == rabort_expected)
         else report_failure("tx_rabort_p1_o pulse count differs from the overflow count");
      $display("frames checked %0d, mismatches %0d, other failures %0d",
               frames_done, mismatch_count, fail_count);
      if (mismatch_count == 0 && fail_count == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

/* wrf_frame_relay_tests.txt */
# command words odd start(hex) errpos outcome
# errpos: send = word (from 1) replaced by rerror, abort = words out before rx_rabort
send 12 0 0100 0 pass
send 9 1 0200 0 pass
send 32 0 1000 0 pass
send 8 1 fff8 0 pass
send 16 0 2000 5 drop
send 10 0 2100 0 pass
send 20 1 3000 0 pass
abort 24 0 4000 6 pass
send 11 1 4100 0 pass
send 25 0 5000 0 pass
send 14 0 6000 1 drop
send 7 1 6100 0 pass
send 1 1 6200 0 pass
send 10 0 7000 0 pass
hold 600 0 8000 0 overrun
send 13 1 9000 0 pass
abort 30 1 a000 3 pass
send 18 0 b000 0 pass
send 3 0 c000 0 pass
send 31 1 d000 0 pass
send 22 0 e000 20 drop
send 6 0 e100 0 pass

/* wrf_frame_relay.f */
+incdir+.
wrf_frame_relay_pkg.sv
wrf_frame_ram.sv
wrf_buffer_arbiter.sv
wrf_desc_fifo.sv
wrf_frame_sink.sv
wrf_frame_source.sv
wrf_frame_relay.sv
tb_clock_gen.sv
wrf_frame_relay_tb.sv
